// ==== source/rx66_pkg.sv ====
`default_nettype none

package rx66_pkg;

    // Line code widths.
    localparam int NB_DATA_CODED = 66;
    localparam int NB_DATA_RAW   = 64;
    localparam int NB_CTRL       = 8;

    // Sync header in bits 65:64 of a coded block.
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Block type byte in payload byte 0 of a control block.
    localparam logic [7:0] TYPE_C  = 8'h1e;                      // All control.
    localparam logic [7:0] TYPE_S  = 8'h78;                      // Start in lane 0.
    localparam logic [7:0] TYPE_T0 = 8'h87;
    localparam logic [7:0] TYPE_T1 = 8'h99;
    localparam logic [7:0] TYPE_T2 = 8'haa;
    localparam logic [7:0] TYPE_T3 = 8'hb4;
    localparam logic [7:0] TYPE_T4 = 8'hcc;
    localparam logic [7:0] TYPE_T5 = 8'hd2;
    localparam logic [7:0] TYPE_T6 = 8'he1;
    localparam logic [7:0] TYPE_T7 = 8'hff;

    // XGMII control characters.
    localparam logic [7:0] CH_IDLE  = 8'h07;
    localparam logic [7:0] CH_START = 8'hfb;
    localparam logic [7:0] CH_TERM  = 8'hfd;
    localparam logic [7:0] CH_ERROR = 8'hfe;

    // Byte i of data goes with ctrl bit i.
    typedef struct packed {
        logic [NB_DATA_RAW-1:0] data;
        logic [NB_CTRL-1:0]     ctrl;
    } xgmii_t;

    typedef enum logic [2:0] {
        BT_C,                                                    // Idle control block.
        BT_S,                                                    // Start block.
        BT_T,                                                    // Any terminate block.
        BT_D,                                                    // Data block.
        BT_E                                                     // Bad sync or type.
    } block_type_e;

    typedef enum logic [2:0] {
        RX_INIT,
        RX_C,
        RX_D,
        RX_T,
        RX_E
    } rx_state_e;

    localparam xgmii_t IDLE_BLOCK = '{
        data: {NB_CTRL{CH_IDLE}},
        ctrl: {NB_CTRL{1'b1}}
    };

    localparam xgmii_t ERROR_BLOCK = '{
        data: {NB_CTRL{CH_ERROR}},
        ctrl: {NB_CTRL{1'b1}}
    };

endpackage

`default_nettype wire

// ==== source/decoder_comparator.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder_comparator
(
    input   wire                                        i_clock,
    input   wire                                        i_rst,
    input   wire                                        i_advance,
    input   wire    [rx66_pkg::NB_DATA_CODED-1  :   0]  i_rx_coded,

    output  rx66_pkg::block_type_e                      o_rx_type,
    output  rx66_pkg::xgmii_t                           o_rx_raw
);

    logic           [1                          :   0]  sync;
    logic           [7                          :   0]  type_byte;
    logic           [rx66_pkg::NB_DATA_RAW-1    :   0]  payload;
    logic           [2                          :   0]  term_pos;

    rx66_pkg::block_type_e                              next_type;
    rx66_pkg::xgmii_t                                   next_raw;

    assign sync      = i_rx_coded[rx66_pkg::NB_DATA_CODED-1 -: 2];
    assign payload   = i_rx_coded[rx66_pkg::NB_DATA_RAW-1:0];
    assign type_byte = payload[7:0];

    // Terminate in lane pos with data below it and idles above it.
    function automatic rx66_pkg::xgmii_t term_block(
        input logic [rx66_pkg::NB_DATA_RAW-1:0] blk_payload,
        input logic [2:0]                       pos
    );
        rx66_pkg::xgmii_t                   blk;
        logic [rx66_pkg::NB_DATA_RAW-1:0]   shifted;
        shifted = blk_payload >> 8;                              // Drop the type byte.
        for (int i = 0; i < rx66_pkg::NB_CTRL; i++) begin
            if (i < int'(pos)) begin
                blk.data[8*i +: 8] = shifted[8*i +: 8];
                blk.ctrl[i]        = 1'b0;
            end else if (i == int'(pos)) begin
                blk.data[8*i +: 8] = rx66_pkg::CH_TERM;
                blk.ctrl[i]        = 1'b1;
            end else begin
                blk.data[8*i +: 8] = rx66_pkg::CH_IDLE;
                blk.ctrl[i]        = 1'b1;
            end
        end
        return blk;
    endfunction

    always_comb begin
        next_type = rx66_pkg::BT_E;
        next_raw  = rx66_pkg::ERROR_BLOCK;
        term_pos  = 3'd0;
        case (sync)
            rx66_pkg::SYNC_DATA: begin
                next_type     = rx66_pkg::BT_D;
                next_raw.data = payload;
                next_raw.ctrl = '0;
            end
            rx66_pkg::SYNC_CTRL: begin
                case (type_byte)
                    rx66_pkg::TYPE_C: begin
                        next_type = rx66_pkg::BT_C;
                        next_raw  = rx66_pkg::IDLE_BLOCK;                // Control codes not decoded.
                    end
                    rx66_pkg::TYPE_S: begin
                        next_type     = rx66_pkg::BT_S;
                        next_raw.data = {payload[rx66_pkg::NB_DATA_RAW-1:8], rx66_pkg::CH_START};
                        next_raw.ctrl = 8'h01;
                    end
                    rx66_pkg::TYPE_T0: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd0;
                    end
                    rx66_pkg::TYPE_T1: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd1;
                    end
                    rx66_pkg::TYPE_T2: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd2;
                    end
                    rx66_pkg::TYPE_T3: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd3;
                    end
                    rx66_pkg::TYPE_T4: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd4;
                    end
                    rx66_pkg::TYPE_T5: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd5;
                    end
                    rx66_pkg::TYPE_T6: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd6;
                    end
                    rx66_pkg::TYPE_T7: begin
                        next_type = rx66_pkg::BT_T;
                        term_pos  = 3'd7;
                    end
                    default: ;                                   // Unsupported type stays BT_E.
                endcase
            end
            default: ;                                           // Sync 00 or 11.
        endcase
        if (next_type == rx66_pkg::BT_T) begin
            next_raw = term_block(payload, term_pos);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_rx_type <= rx66_pkg::BT_E;
            o_rx_raw  <= rx66_pkg::ERROR_BLOCK;
        end else if (i_advance) begin
            o_rx_type <= next_type;
            o_rx_raw  <= next_raw;
        end
    end

endmodule

`default_nettype wire

// ==== source/decoder_fsm_interface.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder_fsm_interface
(
    input   wire                                        i_clock,
    input   wire                                        i_rst,
    input   wire                                        i_advance,
    input   wire    rx66_pkg::block_type_e              i_r_type,

    output  rx66_pkg::block_type_e                      o_r_type,
    output  rx66_pkg::block_type_e                      o_r_type_next
);

    rx66_pkg::block_type_e                              r_type_prev;

    // One block of look-ahead since the comparator already holds the next type.
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            r_type_prev <= rx66_pkg::BT_E;
        end else if (i_advance) begin
            r_type_prev <= i_r_type;
        end
    end

    assign o_r_type      = r_type_prev;
    assign o_r_type_next = i_r_type;                             // Block n+1.

endmodule

`default_nettype wire

// ==== source/decoder_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder_fsm
(
    input   wire                                        i_clock,
    input   wire                                        i_rst,
    input   wire                                        i_enable,
    input   wire                                        i_valid,
    input   wire    rx66_pkg::block_type_e              i_r_type,
    input   wire    rx66_pkg::block_type_e              i_r_type_next,
    input   wire    rx66_pkg::xgmii_t                   i_rx_raw,

    output  logic                                       o_advance,
    output  rx66_pkg::xgmii_t                           o_rx_out,
    output  logic                                       o_fsm_control
);

    rx66_pkg::rx_state_e                                state;
    rx66_pkg::rx_state_e                                state_next;
    rx66_pkg::xgmii_t                                   aligned;
    logic                                               term_ok;

    assign o_advance = i_enable & i_valid;

    // A terminate only counts when the frame really ends after it.
    assign term_ok = (i_r_type == rx66_pkg::BT_T) &&
                     ((i_r_type_next == rx66_pkg::BT_C) || (i_r_type_next == rx66_pkg::BT_S));

    always_comb begin
        state_next = rx66_pkg::RX_E;
        case (state)
            rx66_pkg::RX_INIT,
            rx66_pkg::RX_C,
            rx66_pkg::RX_T: begin
                if (i_r_type == rx66_pkg::BT_C) begin
                    state_next = rx66_pkg::RX_C;
                end else if (i_r_type == rx66_pkg::BT_S) begin
                    state_next = rx66_pkg::RX_D;
                end
            end
            rx66_pkg::RX_D: begin
                if (i_r_type == rx66_pkg::BT_D) begin
                    state_next = rx66_pkg::RX_D;
                end else if (term_ok) begin
                    state_next = rx66_pkg::RX_T;
                end
            end
            rx66_pkg::RX_E: begin
                if (i_r_type == rx66_pkg::BT_C) begin
                    state_next = rx66_pkg::RX_C;
                end else if (i_r_type == rx66_pkg::BT_D) begin
                    state_next = rx66_pkg::RX_D;
                end else if (term_ok) begin
                    state_next = rx66_pkg::RX_T;
                end
            end
            default: state_next = rx66_pkg::RX_E;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state         <= rx66_pkg::RX_INIT;
            aligned       <= rx66_pkg::ERROR_BLOCK;
            o_rx_out      <= rx66_pkg::IDLE_BLOCK;
            o_fsm_control <= 1'b0;
        end else if (o_advance) begin
            aligned       <= i_rx_raw;                           // Lines data up with i_r_type.
            state         <= state_next;
            o_rx_out      <= (state_next == rx66_pkg::RX_E) ? rx66_pkg::ERROR_BLOCK : aligned;
            o_fsm_control <= (state_next == rx66_pkg::RX_C);     // Idle block that may be dropped later.
        end
    end

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder
(
    input   wire                                        i_clock,
    input   wire                                        i_rst,
    input   wire                                        i_enable,
    input   wire                                        i_valid,
    input   wire    [rx66_pkg::NB_DATA_CODED-1  :   0]  i_data,

    output  wire    [rx66_pkg::NB_DATA_RAW-1    :   0]  o_data,
    output  wire    [rx66_pkg::NB_CTRL-1        :   0]  o_ctrl,
    output  wire                                        o_fsm_control
);

    wire                                                advance;
    rx66_pkg::block_type_e                              comparator_type;
    rx66_pkg::xgmii_t                                   comparator_raw;
    rx66_pkg::block_type_e                              lookahead_type;
    rx66_pkg::block_type_e                              lookahead_type_next;
    rx66_pkg::xgmii_t                                   fsm_out;

    decoder_comparator
    u_decoder_comparator
    (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_advance          (advance),
        .i_rx_coded         (i_data),
        .o_rx_type          (comparator_type),
        .o_rx_raw           (comparator_raw)
    );

    decoder_fsm_interface
    u_decoder_fsm_interface
    (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_advance          (advance),
        .i_r_type           (comparator_type),
        .o_r_type           (lookahead_type),
        .o_r_type_next      (lookahead_type_next)
    );

    decoder_fsm
    u_decoder_fsm
    (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_enable           (i_enable),
        .i_valid            (i_valid),
        .i_r_type           (lookahead_type),
        .i_r_type_next      (lookahead_type_next),
        .i_rx_raw           (comparator_raw),
        .o_advance          (advance),
        .o_rx_out           (fsm_out),
        .o_fsm_control      (o_fsm_control)
    );

    assign o_data = fsm_out.data;
    assign o_ctrl = fsm_out.ctrl;

endmodule

`default_nettype wire

// ==== bench/decoder_props.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder_props
(
    input   wire                                    i_clock,
    input   wire                                    i_rst,
    input   wire                                    i_enable,
    input   wire                                    i_valid,
    input   wire    [rx66_pkg::NB_DATA_RAW-1:0]     i_out_data,
    input   wire    [rx66_pkg::NB_CTRL-1:0]         i_out_ctrl,
    input   wire                                    i_fsm_control
);

    // Idle blocks carry control characters in every lane.
    idle_all_ctrl: assert property (@(posedge i_clock) disable iff (i_rst)
        i_fsm_control |-> (i_out_ctrl == '1))
        else $error("o_fsm_control high while o_ctrl is %h", i_out_ctrl);

    hold_on_stall: assert property (@(posedge i_clock)
        (!i_rst && !(i_enable && i_valid)) |=>
            ($stable(i_out_data) && $stable(i_out_ctrl) && $stable(i_fsm_control)))
        else $error("decoder outputs changed without an advance");

    idle_flag_after_reset: assert property (@(posedge i_clock) i_rst |=> !i_fsm_control)
        else $error("o_fsm_control high in the cycle after reset");

endmodule

bind decoder decoder_props u_decoder_props (
    .i_clock        (i_clock),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .i_valid        (i_valid),
    .i_out_data     (o_data),
    .i_out_ctrl     (o_ctrl),
    .i_fsm_control  (o_fsm_control)
);

`default_nettype wire

// ==== bench/decoder_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_FRAMES = 30;
    // Directed blocks, stall cycles and random frames of at most 13 blocks.
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 250 + 160 + RANDOM_FRAMES * 13;
    localparam int WATCHDOG_TIME = 2 * TOTAL_CYCLES * CLK_PERIOD;

    typedef struct packed {
        rx66_pkg::block_type_e  btype;
        rx66_pkg::xgmii_t       blk;
    } entry_t;

    logic                                   i_clock;
    logic                                   i_rst;
    logic                                   i_enable;
    logic                                   i_valid;
    logic   [rx66_pkg::NB_DATA_CODED-1:0]   i_data;
    wire    [rx66_pkg::NB_DATA_RAW-1:0]     o_data;
    wire    [rx66_pkg::NB_CTRL-1:0]         o_ctrl;
    wire                                    o_fsm_control;

    entry_t                                 pipe_q[$];          // Model of the two-block latency.
    logic   [rx66_pkg::NB_DATA_CODED-1:0]   tx_q[$];
    rx66_pkg::rx_state_e                    model_state;
    rx66_pkg::xgmii_t                       exp_out;
    logic                                   exp_idle;
    logic   [31:0]                          lfsr;
    int                                     errors;
    int                                     checks;

    decoder u_dut (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_enable       (i_enable),
        .i_valid        (i_valid),
        .i_data         (i_data),
        .o_data         (o_data),
        .o_ctrl         (o_ctrl),
        .o_fsm_control  (o_fsm_control)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[i] = lfsr[0];
            lfsr     = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [7:0] term_type(input int pos);
        case (pos)
            0:       return rx66_pkg::TYPE_T0;
            1:       return rx66_pkg::TYPE_T1;
            2:       return rx66_pkg::TYPE_T2;
            3:       return rx66_pkg::TYPE_T3;
            4:       return rx66_pkg::TYPE_T4;
            5:       return rx66_pkg::TYPE_T5;
            6:       return rx66_pkg::TYPE_T6;
            default: return rx66_pkg::TYPE_T7;
        endcase
    endfunction

    function automatic logic [65:0] ctrl_block(input logic [7:0] btype, input logic [55:0] rest);
        return {rx66_pkg::SYNC_CTRL, rest, btype};
    endfunction

    function automatic entry_t decode(input logic [65:0] coded);
        entry_t     e;
        logic [7:0] btype;
        e.btype = rx66_pkg::BT_E;
        e.blk   = rx66_pkg::ERROR_BLOCK;
        btype   = coded[7:0];
        if (coded[65:64] == rx66_pkg::SYNC_DATA) begin
            e.btype    = rx66_pkg::BT_D;
            e.blk.data = coded[63:0];
            e.blk.ctrl = '0;
        end else if (coded[65:64] == rx66_pkg::SYNC_CTRL) begin
            if (btype == rx66_pkg::TYPE_C) begin
                e.btype = rx66_pkg::BT_C;
                e.blk   = rx66_pkg::IDLE_BLOCK;
            end else if (btype == rx66_pkg::TYPE_S) begin
                e.btype         = rx66_pkg::BT_S;
                e.blk.data      = coded[63:0];
                e.blk.data[7:0] = rx66_pkg::CH_START;
                e.blk.ctrl      = 8'h01;
            end
            for (int n = 0; n < 8; n++) begin
                if (btype == term_type(n)) begin
                    e.btype              = rx66_pkg::BT_T;
                    e.blk                = rx66_pkg::IDLE_BLOCK;
                    e.blk.data[8*n +: 8] = rx66_pkg::CH_TERM;
                    for (int k = 0; k < n; k++) begin
                        e.blk.data[8*k +: 8] = coded[8*k+8 +: 8];  // Skip the type byte.
                        e.blk.ctrl[k]        = 1'b0;
                    end
                end
            end
        end
        return e;
    endfunction

    function automatic rx66_pkg::rx_state_e next_state(input rx66_pkg::rx_state_e s,
                                                       input rx66_pkg::block_type_e cur,
                                                       input rx66_pkg::block_type_e nxt);
        logic ends;
        ends = (cur == rx66_pkg::BT_T) && (nxt == rx66_pkg::BT_C || nxt == rx66_pkg::BT_S);
        if (s == rx66_pkg::RX_D) begin
            if (cur == rx66_pkg::BT_D) return rx66_pkg::RX_D;
            return ends ? rx66_pkg::RX_T : rx66_pkg::RX_E;
        end
        if (s == rx66_pkg::RX_E) begin
            if (cur == rx66_pkg::BT_C) return rx66_pkg::RX_C;
            if (cur == rx66_pkg::BT_D) return rx66_pkg::RX_D;
            return ends ? rx66_pkg::RX_T : rx66_pkg::RX_E;
        end
        if (cur == rx66_pkg::BT_C) return rx66_pkg::RX_C;
        return (cur == rx66_pkg::BT_S) ? rx66_pkg::RX_D : rx66_pkg::RX_E;
    endfunction

    // Starts and ends on a falling edge.
    task automatic apply_cycle(input logic [65:0] coded, input logic en, input logic vld);
        entry_t cur;
        i_data   = coded;
        i_enable = en;
        i_valid  = vld;
        @(posedge i_clock);
        @(negedge i_clock);
        if (en && vld) begin
            pipe_q.push_back(decode(coded));
            cur         = pipe_q.pop_front();
            model_state = next_state(model_state, cur.btype, pipe_q[0].btype);
            exp_out     = (model_state == rx66_pkg::RX_E) ? rx66_pkg::ERROR_BLOCK : cur.blk;
            exp_idle    = (model_state == rx66_pkg::RX_C);
        end
        check_value(o_data, exp_out.data, "o_data");
        check_value(64'(o_ctrl), 64'(exp_out.ctrl), "o_ctrl");
        check_value(64'(o_fsm_control), 64'(exp_idle), "o_fsm_control");
    endtask

    task automatic add_idles(input int count);
        repeat (count) tx_q.push_back(ctrl_block(rx66_pkg::TYPE_C, 56'h0));
    endtask

    task automatic add_frame(input int n_data, input int pos);
        logic [63:0] bits;
        take_bits(56, bits);
        tx_q.push_back(ctrl_block(rx66_pkg::TYPE_S, bits[55:0]));
        for (int i = 0; i < n_data; i++) begin
            take_bits(64, bits);
            tx_q.push_back({rx66_pkg::SYNC_DATA, bits});
        end
        take_bits(8 * pos, bits);
        tx_q.push_back(ctrl_block(term_type(pos), bits[55:0]));
    endtask

    task automatic send_blocks(input logic with_stalls);
        logic [63:0] r;
        logic        en;
        logic        vld;
        while (tx_q.size() > 0) begin
            en  = 1'b1;
            vld = 1'b1;
            if (with_stalls) begin
                take_bits(4, r);
                en  = (r[1:0] != 2'b00);
                vld = (r[3:2] != 2'b00);
            end
            if (en && vld) begin
                apply_cycle(tx_q.pop_front(), 1'b1, 1'b1);
            end else begin
                take_bits(64, r);
                apply_cycle({2'b11, r}, en, vld);               // Must not be taken.
            end
        end
    endtask

    task automatic reset_values();
        check_value(o_data, rx66_pkg::IDLE_BLOCK.data, "o_data after reset");
        check_value(64'(o_ctrl), 64'(rx66_pkg::IDLE_BLOCK.ctrl), "o_ctrl after reset");
        check_value(64'(o_fsm_control), 64'(1'b0), "o_fsm_control after reset");
    endtask

    task automatic idle_frames();
        add_idles(3);
        add_frame(3, 5);
        add_idles(2);
        add_frame(0, 2);
        add_idles(3);
        send_blocks(1'b0);
    endtask

    task automatic terminate_lanes();
        for (int p = 0; p < 8; p++) begin
            add_frame(1, p);
            if (p % 2 == 1) begin                                 // Even lanes run into a start.
                add_idles(1);
            end
        end
        add_idles(1);
        send_blocks(1'b0);
    endtask

    task automatic sequence_errors();
        logic [63:0] bits;
        take_bits(64, bits);
        add_idles(2);
        tx_q.push_back({2'b00, bits});                            // Bad sync header.
        tx_q.push_back({2'b11, bits});
        tx_q.push_back(ctrl_block(rx66_pkg::TYPE_T5, bits[55:0])); // Terminate while in RX_E.
        add_idles(2);
        tx_q.push_back({rx66_pkg::SYNC_DATA, bits});              // Data right after idle.
        add_idles(2);
        tx_q.push_back(ctrl_block(rx66_pkg::TYPE_S, bits[55:0]));
        tx_q.push_back(ctrl_block(rx66_pkg::TYPE_T3, bits[55:0]));
        tx_q.push_back({rx66_pkg::SYNC_DATA, bits});              // Terminate then data.
        tx_q.push_back(ctrl_block(rx66_pkg::TYPE_T2, bits[55:0]));
        add_idles(1);
        tx_q.push_back(ctrl_block(8'h2d, bits[55:0]));            // Mixed type not supported.
        add_frame(2, 4);                                          // Start while in RX_E.
        add_idles(2);
        send_blocks(1'b0);
    endtask

    task automatic stalled_traffic();
        add_idles(2);
        add_frame(4, 6);
        add_idles(1);
        add_frame(7, 1);
        add_idles(2);
        add_frame(0, 0);
        add_idles(3);
        send_blocks(1'b1);
    endtask

    task automatic random_traffic();
        logic [63:0] r;
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            take_bits(2, r);
            add_idles(int'(r[1:0]) + 1);
            take_bits(6, r);
            add_frame(int'(r[2:0]), int'(r[5:3]));
        end
        add_idles(2);
        send_blocks(1'b0);
    endtask

    initial begin
        entry_t reset_entry;
        i_rst             = 1'b1;
        i_enable          = 1'b0;
        i_valid           = 1'b0;
        i_data            = '0;
        lfsr              = 32'h3c6f_5feb;
        errors            = 0;
        checks            = 0;
        model_state       = rx66_pkg::RX_INIT;
        exp_out           = rx66_pkg::IDLE_BLOCK;
        exp_idle          = 1'b0;
        reset_entry.btype = rx66_pkg::BT_E;                       // Comparator and look-ahead.
        reset_entry.blk   = rx66_pkg::ERROR_BLOCK;
        pipe_q.push_back(reset_entry);
        pipe_q.push_back(reset_entry);
        repeat (RESET_CYCLES) @(posedge i_clock);
        @(negedge i_clock);
        i_rst = 1'b0;
        reset_values();
        idle_frames();
        terminate_lanes();
        sequence_errors();
        stalled_traffic();
        random_traffic();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired, the run did not finish within %0d ns", WATCHDOG_TIME);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== decoder.f ====
source/rx66_pkg.sv
source/decoder_comparator.sv
source/decoder_fsm_interface.sv
source/decoder_fsm.sv
source/decoder.sv
bench/decoder_props.sv
bench/decoder_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = decoder_tb
FILELIST  = decoder.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
